// ==== hw/rv_pkg.sv ====
/*
 * rv execution slice shared types
 * register index, instruction word, alu operations and rv32i encodings
 */

package rv_pkg;

  // architectural register count, x0 included
  localparam int reg_count = 32;

  // 5-bit register index
  typedef logic [4:0] reg_addr_t;

  // raw 32-bit instruction word
  typedef logic [31:0] instr_t;

  // alu operations, one per rv32i arithmetic/logic/shift/compare op
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // major opcodes handled by the slice
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  // funct3 values, shared by op and op-imm
  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll     = 3'b001;
  localparam logic [2:0] funct3_slt     = 3'b010;
  localparam logic [2:0] funct3_sltu    = 3'b011;
  localparam logic [2:0] funct3_xor     = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_and     = 3'b111;

  // funct7 values: base encoding and the sub/sra alternate
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

endpackage

// ==== hw/regfile_if.sv ====
/*
 * register file bus
 * two read ports and one write port, core and regfile modports
 */

`timescale 1ns/1ps

interface regfile_if #(
  parameter int xlen = 32
);
  import rv_pkg::*;

  // read side
  reg_addr_t         read_address1;
  reg_addr_t         read_address2;
  logic [xlen-1:0]   read_data1;
  logic [xlen-1:0]   read_data2;
  // write side, write_enable sampled at the rising edge
  reg_addr_t         write_address;
  logic [xlen-1:0]   write_data;
  logic              write_enable;

  // core drives addresses and write data, gets read data back
  modport core (
    output read_address1, read_address2, write_address, write_data, write_enable,
    input  read_data1, read_data2
  );

  // register file side
  modport regfile (
    input  read_address1, read_address2, write_address, write_data, write_enable,
    output read_data1, read_data2
  );

endinterface

// ==== hw/register_file.sv ====
/*
 * register file, x0 hardwired to zero
 * two combinational read ports, one clocked write port, write-through bypass
 */

`timescale 1ns/1ps

module register_file #(
  parameter int xlen = 32
) (
  input logic        clock,
  input logic        arst_n,
  regfile_if.regfile rf
);
  import rv_pkg::*;

  // storage for x1..x31, x0 has no flop behind it
  logic [xlen-1:0] regs [1:reg_count-1];

  // write is live when enabled and not aimed at x0
  logic write_live;

  assign write_live = rf.write_enable && (rf.write_address != '0);

  // one read port
  // zero for x0, bypass the word being written, else the stored word
  function automatic logic [xlen-1:0] read_port(input reg_addr_t address);
    logic [xlen-1:0] data;
    if (address == '0) begin
      data = '0;
    end else if (write_live && (address == rf.write_address)) begin
      data = rf.write_data;
    end else begin
      data = regs[address];
    end
    return data;
  endfunction

  // combinational reads
  always_comb begin
    rf.read_data1 = read_port(rf.read_address1);
    rf.read_data2 = read_port(rf.read_address2);
  end

  // clocked write, all registers clear on reset
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[rf.write_address] <= rf.write_data;
    end
  end

endmodule

// ==== hw/instr_decoder.sv ====
/*
 * rv32i decoder for op, op-imm and lui
 * register fields, alu op, operand select, immediate and legal flag
 */

`timescale 1ns/1ps

module instr_decoder (
  input  rv_pkg::instr_t    instr,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::alu_op_e   alu_op,
  output logic              use_imm,
  output logic [31:0]       imm,
  output logic              is_lui,
  output logic              legal
);
  import rv_pkg::*;

  // instruction fields
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_u;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // register indices sit at fixed positions in every format
  assign rd  = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  // i-type: sign-extended 12 bits, u-type: upper 20 bits
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    // defaults describe an illegal word
    alu_op  = alu_add;
    use_imm = 1'b0;
    is_lui  = 1'b0;
    imm     = imm_i;
    legal   = 1'b0;

    case (opcode)
      opcode_op: begin
        // register-register, funct7 picks sub and sra
        case (funct3)
          funct3_add_sub: alu_op = (funct7 == funct7_alt) ? alu_sub : alu_add;
          funct3_sll:     alu_op = alu_sll;
          funct3_slt:     alu_op = alu_slt;
          funct3_sltu:    alu_op = alu_sltu;
          funct3_xor:     alu_op = alu_xor;
          funct3_srl_sra: alu_op = (funct7 == funct7_alt) ? alu_sra : alu_srl;
          funct3_or:      alu_op = alu_or;
          default:        alu_op = alu_and;
        endcase
        // only add/sub and srl/sra accept the alternate funct7
        if (funct7 == funct7_base) begin
          legal = 1'b1;
        end else if (funct7 == funct7_alt) begin
          legal = (funct3 == funct3_add_sub) || (funct3 == funct3_srl_sra);
        end
      end

      opcode_op_imm: begin
        use_imm = 1'b1;
        case (funct3)
          funct3_add_sub: alu_op = alu_add;
          funct3_sll:     alu_op = alu_sll;
          funct3_slt:     alu_op = alu_slt;
          funct3_sltu:    alu_op = alu_sltu;
          funct3_xor:     alu_op = alu_xor;
          funct3_srl_sra: alu_op = (funct7 == funct7_alt) ? alu_sra : alu_srl;
          funct3_or:      alu_op = alu_or;
          default:        alu_op = alu_and;
        endcase
        // shift immediates carry funct7 in the top bits, the rest take any value
        if (funct3 == funct3_sll) begin
          legal = (funct7 == funct7_base);
        end else if (funct3 == funct3_srl_sra) begin
          legal = (funct7 == funct7_base) || (funct7 == funct7_alt);
        end else begin
          legal = 1'b1;
        end
      end

      opcode_lui: begin
        // lui is zero + u-immediate through the adder
        alu_op  = alu_add;
        use_imm = 1'b1;
        is_lui  = 1'b1;
        imm     = imm_u;
        legal   = 1'b1;
      end

      default: legal = 1'b0;
    endcase
  end

endmodule

// ==== hw/alu.sv ====
/*
 * integer alu
 * add, sub, shifts, signed and unsigned compare, bitwise logic
 */

`timescale 1ns/1ps

module alu #(
  parameter int xlen = 32
) (
  input  rv_pkg::alu_op_e op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);
  import rv_pkg::*;

  // shift amount from the low five bits of b
  logic [4:0] shamt;
  // compare results
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      // compares give 1 or 0 in bit 0
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      // arithmetic shift keeps the sign bit
      alu_sra:  result = $unsigned($signed(a) >>> shamt);
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

// ==== hw/exec_core.sv ====
/*
 * integer execution slice top
 * decode and register read, one execute register, write-back one cycle later
 */

`timescale 1ns/1ps

module exec_core #(
  parameter int xlen = 32
) (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              instr_valid,
  input  rv_pkg::instr_t    instr,
  output logic              wb_valid,
  output rv_pkg::reg_addr_t wb_address,
  output logic [xlen-1:0]   wb_data,
  output logic              illegal_instr
);
  import rv_pkg::*;

  // decode outputs
  reg_addr_t       dec_rs1;
  reg_addr_t       dec_rs2;
  reg_addr_t       dec_rd;
  alu_op_e         dec_op;
  logic            dec_use_imm;
  logic [31:0]     dec_imm;
  logic            dec_is_lui;
  logic            dec_legal;
  // immediate sized to the operand width
  logic [xlen-1:0] imm_x;

  // execute register
  logic [xlen-1:0] ex_a;
  logic [xlen-1:0] ex_b;
  alu_op_e         ex_op;
  reg_addr_t       ex_rd;
  logic            ex_valid;
  logic            ex_illegal;
  logic [xlen-1:0] alu_result;

  regfile_if #(.xlen(xlen)) rf_bus ();

  register_file #(.xlen(xlen)) u_regfile (
    .clock  (clock),
    .arst_n (arst_n),
    .rf     (rf_bus.regfile)
  );

  instr_decoder u_decoder (
    .instr   (instr),
    .rs1     (dec_rs1),
    .rs2     (dec_rs2),
    .rd      (dec_rd),
    .alu_op  (dec_op),
    .use_imm (dec_use_imm),
    .imm     (dec_imm),
    .is_lui  (dec_is_lui),
    .legal   (dec_legal)
  );

  alu #(.xlen(xlen)) u_alu (
    .op     (ex_op),
    .a      (ex_a),
    .b      (ex_b),
    .result (alu_result)
  );

  assign imm_x = xlen'($signed(dec_imm));

  // decode stage reads both sources, bypass handles the execute-stage rd
  assign rf_bus.read_address1 = dec_rs1;
  assign rf_bus.read_address2 = dec_rs2;

  // write-back from the execute stage
  assign rf_bus.write_enable  = ex_valid;
  assign rf_bus.write_address = ex_rd;
  assign rf_bus.write_data    = alu_result;

  // control bits, cleared on reset
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid   <= 1'b0;
      ex_illegal <= 1'b0;
    end else begin
      // x0 destination still executes but never writes back
      ex_valid   <= instr_valid && dec_legal && (dec_rd != '0);
      ex_illegal <= instr_valid && !dec_legal;
    end
  end

  // operand payload, loaded on each accepted word
  always_ff @(posedge clock) begin
    if (instr_valid) begin
      ex_a  <= dec_is_lui ? '0 : rf_bus.read_data1;
      ex_b  <= dec_use_imm ? imm_x : rf_bus.read_data2;
      ex_op <= dec_op;
      ex_rd <= dec_rd;
    end
  end

  assign wb_valid      = ex_valid;
  assign wb_address    = ex_rd;
  assign wb_data       = alu_result;
  assign illegal_instr = ex_illegal;

endmodule

// ==== test/clock_gen.sv ====
/*
 * testbench clock and reset
 * free-running clock, active-low reset held for a few cycles
 */

`timescale 1ns/1ps

module clock_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 3
) (
  output logic clock,
  output logic arst_n
);

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2.0) clock = ~clock;
  end

  // release on a rising edge, after the flops have seen reset
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    arst_n <= 1'b1;
  end

endmodule

// ==== test/exec_core_checker.sv ====
/*
 * exec_core protocol checker
 * write-back timing, x0 protection, illegal flag and reset values
 */

`timescale 1ns/1ps

module exec_core_checker (
  input logic              clock,
  input logic              arst_n,
  input logic              instr_valid,
  input rv_pkg::instr_t    instr,
  input logic              wb_valid,
  input rv_pkg::reg_addr_t wb_address,
  input logic              illegal_instr
);
  import rv_pkg::*;

  // failed assertions so far
  int   fail_count = 0;
  // accepted word that must write back next cycle
  logic writes_back;

  // legality straight from the rv32i encoding rules
  function automatic logic word_is_legal(input instr_t w);
    logic [6:0] f7;
    logic [2:0] f3;
    logic       ok;
    f7 = w[31:25];
    f3 = w[14:12];
    case (w[6:0])
      opcode_op: begin
        ok = (f7 == funct7_base) ||
             ((f7 == funct7_alt) && (f3 == funct3_add_sub || f3 == funct3_srl_sra));
      end
      opcode_op_imm: begin
        // only the shift immediates constrain the top bits
        ok = (f3 == funct3_sll) ? (f7 == funct7_base) :
             (f3 == funct3_srl_sra) ? (f7 == funct7_base || f7 == funct7_alt) : 1'b1;
      end
      opcode_lui: ok = 1'b1;
      default:    ok = 1'b0;
    endcase
    return ok;
  endfunction

  assign writes_back = instr_valid && word_is_legal(instr) && (instr[11:7] != '0);

  // accepted legal word with a real destination writes back next cycle
  write_back_follows: assert property (@(posedge clock) disable iff (!arst_n)
    writes_back |=> wb_valid)
    else begin
      fail_count++;
      $error("write-back missing after a legal instruction");
    end

  // and nothing else may write back
  write_back_has_cause: assert property (@(posedge clock) disable iff (!arst_n)
    wb_valid |-> $past(writes_back))
    else begin
      fail_count++;
      $error("write-back without a legal instruction the cycle before");
    end

  // x0 is never a write-back target
  no_x0_write: assert property (@(posedge clock) disable iff (!arst_n)
    wb_valid |-> (wb_address != '0))
    else begin
      fail_count++;
      $error("write-back aimed at x0");
    end

  illegal_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
    !(wb_valid && illegal_instr))
    else begin
      fail_count++;
      $error("illegal_instr and wb_valid high together");
    end

  // outputs stay quiet while reset is held
  quiet_in_reset: assert property (@(posedge clock)
    !arst_n |-> (!wb_valid && !illegal_instr))
    else begin
      fail_count++;
      $error("output active during reset");
    end

endmodule

bind exec_core exec_core_checker u_checker (
  .clock         (clock),
  .arst_n        (arst_n),
  .instr_valid   (instr_valid),
  .instr         (instr),
  .wb_valid      (wb_valid),
  .wb_address    (wb_address),
  .illegal_instr (illegal_instr)
);

// ==== test/exec_core_tb.sv ====
/*
 * exec_core testbench
 * shadow register model, directed and random instruction streams
 */

`timescale 1ns/1ps

module exec_core_tb;
  import rv_pkg::*;

  // what the slice should show one cycle after an issue
  typedef struct packed {
    logic        wb;
    logic        illegal;
    reg_addr_t   address;
    logic [31:0] data;
  } wb_expect_t;

  // tests take about 540 cycles, limit leaves close to double
  localparam int max_cycles = 1000;

  logic        clock;
  logic        arst_n;
  logic        instr_valid;
  instr_t      instr;
  logic        wb_valid;
  reg_addr_t   wb_address;
  logic [31:0] wb_data;
  logic        illegal_instr;

  // shadow copy of the architectural registers, x0 never written
  logic [31:0] shadow [reg_count];
  wb_expect_t  pending;
  string       test_name;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;

  clock_gen #(.period_ns(10), .reset_cycles(3)) u_clock (
    .clock  (clock),
    .arst_n (arst_n)
  );

  exec_core #(.xlen(32)) uut (
    .clock         (clock),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .wb_valid      (wb_valid),
    .wb_address    (wb_address),
    .wb_data       (wb_data),
    .illegal_instr (illegal_instr)
  );

  always @(posedge clock) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= max_cycles);
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  // instruction encoders
  function automatic instr_t rtype_word(input logic [2:0] f3, input logic [6:0] f7,
                                        input reg_addr_t rd, input reg_addr_t rs1,
                                        input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, opcode_op};
  endfunction

  function automatic instr_t itype_word(input logic [2:0] f3, input logic [11:0] imm,
                                        input reg_addr_t rd, input reg_addr_t rs1);
    return {imm, rs1, f3, rd, opcode_op_imm};
  endfunction

  function automatic instr_t utype_word(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, opcode_lui};
  endfunction

  // rv32i result rules, alt selects sub and sra
  function automatic logic [31:0] model_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    logic [4:0]  sh;
    sh = b[4:0];
    case (f3)
      funct3_add_sub: r = alt ? a - b : a + b;
      funct3_sll:     r = a << sh;
      // signed order by flipping the sign bits
      funct3_slt:     r = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      funct3_sltu:    r = {31'b0, a < b};
      funct3_xor:     r = a ^ b;
      // vacated bits take the sign for sra
      funct3_srl_sra: r = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
      funct3_or:      r = a | b;
      default:        r = a & b;
    endcase
    return r;
  endfunction

  // predicts the write-back of one issue and updates the shadow registers
  function automatic wb_expect_t predict(input logic valid, input instr_t w);
    wb_expect_t  e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic        legal;
    logic        alt;
    f3    = w[14:12];
    f7    = w[31:25];
    a     = shadow[w[19:15]];
    b     = '0;
    e     = '0;
    legal = 1'b0;
    alt   = (f7 == funct7_alt);
    if (w[6:0] == opcode_op) begin
      b     = shadow[w[24:20]];
      legal = (f7 == funct7_base) || (alt && (f3 == funct3_add_sub || f3 == funct3_srl_sra));
    end else if (w[6:0] == opcode_op_imm) begin
      b     = {{20{w[31]}}, w[31:20]};
      // no subi, the top bits only matter for shifts
      alt   = alt && (f3 == funct3_srl_sra);
      legal = (f3 == funct3_sll) ? (f7 == funct7_base) :
              (f3 == funct3_srl_sra) ? (f7 == funct7_base || alt) : 1'b1;
    end else if (w[6:0] == opcode_lui) begin
      a     = '0;
      b     = {w[31:12], 12'h000};
      f3    = funct3_add_sub;
      alt   = 1'b0;
      legal = 1'b1;
    end
    if (valid && !legal) begin
      e.illegal = 1'b1;
    end else if (valid && (w[11:7] != '0)) begin
      e.wb             = 1'b1;
      e.address        = w[11:7];
      e.data           = model_result(f3, alt, a, b);
      shadow[w[11:7]]  = e.data;
    end
    return e;
  endfunction

  task automatic compare_writeback(input wb_expect_t e);
    assert (wb_valid === e.wb) else begin
      errors++;
      if (e.wb) $display("%s: write-back to x%0d missing", test_name, e.address);
      else $display("%s: unexpected write-back to x%0d", test_name, wb_address);
    end
    assert (illegal_instr === e.illegal) else begin
      errors++;
      $display("%s: illegal_instr %s", test_name,
               e.illegal ? "missing for an illegal word" : "raised without an illegal word");
    end
    if (e.wb && wb_valid) begin
      assert (wb_address === e.address) else begin
        errors++;
        $display("mismatch %s wb_address expected %0d actual %0d",
                 test_name, e.address, wb_address);
      end
      assert (wb_data === e.data) else begin
        errors++;
        $display("mismatch %s wb_data expected %h actual %h", test_name, e.data, wb_data);
      end
    end
  endtask

  // drive one cycle, then check the word issued the cycle before
  task automatic issue(input logic valid, input instr_t w);
    wb_expect_t next;
    @(posedge clock);
    instr_valid <= valid;
    instr       <= w;
    next = predict(valid, w);
    @(negedge clock);
    compare_writeback(pending);
    pending = next;
  endtask

  // lui plus addi, upper part rounded for the sign of the low twelve bits
  task automatic load_reg(input reg_addr_t rd, input logic [31:0] value);
    issue(1'b1, utype_word(value[31:12] + value[11], rd));
    issue(1'b1, itype_word(funct3_add_sub, value[11:0], rd, rd));
  endtask

  function automatic instr_t random_word();
    logic [2:0]  f3;
    logic [11:0] imm;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    instr_t      w;
    f3  = 3'($urandom);
    imm = 12'($urandom);
    rd  = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    case ($urandom % 8)
      0, 1, 2: begin
        w = rtype_word(f3, ((f3 == funct3_add_sub || f3 == funct3_srl_sra) && imm[0]) ?
                       funct7_alt : funct7_base, rd, rs1, rs2);
      end
      3, 4: begin
        // shift immediates carry a funct7
        if (f3 == funct3_sll) imm[11:5] = funct7_base;
        if (f3 == funct3_srl_sra) imm[11:5] = imm[0] ? funct7_alt : funct7_base;
        w = itype_word(f3, imm, rd, rs1);
      end
      5: w = utype_word(20'($urandom), rd);
      // load opcode, not handled by the slice
      6: w = {imm, rs1, f3, rd, 7'b0000011};
      // multiply-extension funct7
      default: w = rtype_word(f3, 7'b0000001, rd, rs1, rs2);
    endcase
    return w;
  endfunction

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  // one idle cycle flushes the last write-back of the test
  task automatic finish_test();
    issue(1'b0, '0);
    tests_run++;
    if (errors != test_errors) tests_failed++;
    $display("test %s: %s, %0d errors", test_name,
             (errors == test_errors) ? "pass" : "fail", errors - test_errors);
  endtask

  initial begin
    logic [2:0] f3;
    logic [6:0] f7;
    reg_addr_t  prev;
    reg_addr_t  nxt;
    reg_addr_t  src_a [5];
    reg_addr_t  src_b [5];
    void'($urandom(32'h5b3c));
    instr_valid = 1'b0;
    instr       = '0;
    pending     = '0;
    for (int i = 0; i < reg_count; i++) shadow[i] = '0;
    src_a = '{5'd1, 5'd3, 5'd20, 5'd21, 5'd22};
    src_b = '{5'd2, 5'd4, 5'd21, 5'd20, 5'd23};
    wait (arst_n === 1'b1);

    start_test("reset_and_x0");
    for (int r = 1; r < reg_count; r++) begin
      issue(1'b1, rtype_word(funct3_add_sub, funct7_base, 5'(r), 5'(r), 5'd0));
    end
    issue(1'b1, itype_word(funct3_add_sub, 12'h155, 5'd0, 5'd0));
    issue(1'b1, utype_word(20'habcde, 5'd0));
    issue(1'b1, rtype_word(funct3_add_sub, funct7_base, 5'd9, 5'd0, 5'd0));
    finish_test();

    start_test("immediate_and_lui");
    issue(1'b1, utype_word(20'h12345, 5'd1));
    issue(1'b1, itype_word(funct3_add_sub, 12'h678, 5'd2, 5'd1));
    issue(1'b1, itype_word(funct3_add_sub, 12'hfff, 5'd3, 5'd0));
    issue(1'b1, itype_word(funct3_slt, 12'h000, 5'd4, 5'd3));
    issue(1'b1, itype_word(funct3_sltu, 12'hfff, 5'd5, 5'd1));
    issue(1'b1, itype_word(funct3_xor, 12'h800, 5'd6, 5'd2));
    issue(1'b1, itype_word(funct3_or, 12'h7ff, 5'd7, 5'd1));
    issue(1'b1, itype_word(funct3_and, 12'hf0f, 5'd8, 5'd3));
    issue(1'b1, itype_word(funct3_sll, {funct7_base, 5'd31}, 5'd9, 5'd3));
    issue(1'b1, itype_word(funct3_srl_sra, {funct7_base, 5'd4}, 5'd10, 5'd9));
    issue(1'b1, itype_word(funct3_srl_sra, {funct7_alt, 5'd31}, 5'd11, 5'd9));
    issue(1'b1, itype_word(funct3_srl_sra, {funct7_alt, 5'd3}, 5'd12, 5'd6));
    finish_test();

    start_test("register_ops");
    for (int r = 1; r <= 4; r++) load_reg(5'(r), $urandom);
    load_reg(5'd20, 32'h8000_0000);
    load_reg(5'd21, 32'h7fff_ffff);
    load_reg(5'd22, 32'hffff_ffff);
    load_reg(5'd23, 32'd31);
    // codes 8 and 9 are sub and sra
    for (int f = 0; f < 10; f++) begin
      f3 = (f < 8) ? 3'(f) : ((f == 8) ? funct3_add_sub : funct3_srl_sra);
      f7 = (f < 8) ? funct7_base : funct7_alt;
      for (int p = 0; p < 5; p++) begin
        issue(1'b1, rtype_word(f3, f7, 5'(10 + p), src_a[p], src_b[p]));
      end
    end
    finish_test();

    start_test("dependency_chain");
    load_reg(5'd1, $urandom);
    prev = 5'd1;
    for (int i = 0; i < 20; i++) begin
      nxt = 5'(2 + i % 6);
      case (i % 3)
        0: issue(1'b1, itype_word(funct3_add_sub, 12'($urandom), nxt, prev));
        1: issue(1'b1, rtype_word(funct3_xor, funct7_base, nxt, prev, 5'd1));
        default: issue(1'b1, rtype_word(funct3_add_sub, funct7_alt, nxt, prev, 5'd1));
      endcase
      prev = nxt;
    end
    finish_test();

    start_test("illegal_words");
    load_reg(5'd7, 32'h1234_5678);
    issue(1'b1, {12'h010, 5'd1, 3'b010, 5'd7, 7'b0000011});
    issue(1'b1, rtype_word(funct3_add_sub, 7'b0000001, 5'd7, 5'd1, 5'd2));
    issue(1'b1, rtype_word(funct3_sll, funct7_alt, 5'd7, 5'd1, 5'd2));
    issue(1'b1, itype_word(funct3_sll, {funct7_alt, 5'd3}, 5'd7, 5'd1));
    issue(1'b1, itype_word(funct3_srl_sra, {7'b0000001, 5'd3}, 5'd7, 5'd1));
    issue(1'b1, {20'h00010, 5'd7, 7'b1101111});
    issue(1'b1, rtype_word(funct3_add_sub, funct7_base, 5'd8, 5'd7, 5'd0));
    finish_test();

    start_test("random_mix");
    for (int n = 0; n < 300; n++) begin
      // idle cycles carry a junk word that must be ignored
      if ($urandom % 4 == 0) issue(1'b0, random_word());
      issue(1'b1, random_word());
    end
    finish_test();

    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, uut.u_checker.fail_count);
    if (errors == 0 && uut.u_checker.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== exec_core.f ====
hw/rv_pkg.sv
hw/regfile_if.sv
hw/register_file.sv
hw/instr_decoder.sv
hw/alu.sv
hw/exec_core.sv
test/clock_gen.sv
test/exec_core_checker.sv
test/exec_core_tb.sv
